// File: Makefile
VERILATOR ?= verilator
TOP ?= tbAdb
FLIST ?= vlog.f
OBJDIR ?= obj_dir
VFLAGS ?= -sv --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: adbBusCtrl.sv
/* Host side ADB sequencer driven by the 2-bit VIA state. viaBusy holds back
   talk bytes; a phase left before its byte is strobed drops that byte */
`timescale 1ns/1ps

module adbBusCtrl #(
	parameter int TalkInterval = 88000
) (
	input logic clk,
	input logic reset,
	input adbPkg::adbPhase viaState,
	input logic viaBusy,
	input adbPkg::adbByte dinByte,
	input logic dinStrobe,
	input logic kbdSelected,
	input adbPkg::adbWord kbdTalkWord,
	input logic kbdPending,
	input logic mouseSelected,
	input adbPkg::adbWord mouseTalkWord,
	input logic mousePending,
	output adbPkg::adbCmd curCmd,
	output adbPkg::adbAddr curAddr,
	output logic [3:0] respCnt,
	output adbPkg::adbPhase phase,
	output adbPkg::adbByte doutByte,
	output logic doutStrobe,
	output logic listen,
	output logic serviceReqN
);
	import adbPkg::*;

	// Same command twice in a row waits a double interval before autopoll
	localparam int TimerW = $clog2(2 * TalkInterval + 1);

	logic [TimerW-1:0] talkTimer;
	logic idleActive;
	logic sendResponse;
	logic isTalk;
	logic isListen;
	logic isResetFlush;
	logic dataPhase;
	logic parityOk;
	logic anySelected;
	logic irq;
	logic irqInhibit;
	adbCmd newCmd;
	adbAddr newAddr;
	adbWord talkWord;
	adbByte sendByte;

	assign newCmd = dinByte[3:0];
	assign newAddr = dinByte[7:4];

	assign isTalk = curCmd[3:2] == CmdTalk;
	assign isListen = curCmd[3:2] == CmdListen;
	assign isResetFlush = curCmd[3:1] == 3'b000;
	assign dataPhase = viaState == PhaseEven || viaState == PhaseOdd;
	assign parityOk = respCnt[0] == viaState[1]; // Even phase wants even count
	assign anySelected = kbdSelected || mouseSelected;

	// Nobody answering reads as all ones
	assign talkWord = kbdSelected ? kbdTalkWord : (mouseSelected ? mouseTalkWord : RegIdle);

	// respCnt has already advanced when the byte goes out
	always_comb begin
		sendByte = 8'hFF;
		if (isTalk) begin
			if (respCnt == 4'd1)
				sendByte = talkWord[15:8];
			else if (respCnt == 4'd2)
				sendByte = talkWord[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PhaseIdle;
			curCmd <= CmdReset;
			curAddr <= '0;
			respCnt <= '0;
			listen <= 1'b0;
			doutStrobe <= 1'b0;
			sendResponse <= 1'b0;
			idleActive <= 1'b0;
			talkTimer <= '0;
		end else begin
			phase <= viaState;
			doutStrobe <= 1'b0;
			sendResponse <= 1'b0;

			case (viaState)
				PhaseCmd: begin
					respCnt <= '0;
					if (phase != PhaseCmd)
						listen <= 1'b1; // Waiting for the command byte
					if (dinStrobe) begin
						curCmd <= newCmd;
						curAddr <= newAddr;
						listen <= 1'b0;
						idleActive <= 1'b1;
						if (newCmd != curCmd || newAddr != curAddr)
							talkTimer <= TimerW'(TalkInterval);
						else
							talkTimer <= TimerW'(2 * TalkInterval);
					end
				end

				PhaseEven, PhaseOdd: begin
					// Reset and Flush answer with a single byte
					if (!viaBusy && parityOk && (isTalk || (isResetFlush && respCnt == 4'd0))) begin
						sendResponse <= 1'b1;
						respCnt <= respCnt + 4'd1;
					end
					if (sendResponse) begin
						doutByte <= sendByte;
						doutStrobe <= 1'b1;
					end

					if (phase != viaState)
						listen <= isListen;
					if (isListen && parityOk && dinStrobe) begin
						listen <= 1'b0;
						respCnt <= respCnt + 4'd1;
					end
				end

				default: begin
					// Autopoll byte once the talk interval runs out
					if (isTalk && idleActive) begin
						if (talkTimer != '0) begin
							talkTimer <= talkTimer - 1'b1;
						end else begin
							doutByte <= 8'hFF;
							doutStrobe <= 1'b1;
							idleActive <= 1'b0;
						end
					end
				end
			endcase
		end
	end

	// SRQ from an unaddressed device with data, or when no device answers
	assign irq = (!kbdSelected && kbdPending) || (!mouseSelected && mousePending) || !anySelected;
	assign irqInhibit = respCnt < 4'd3 &&
		((kbdSelected && kbdPending) || (mouseSelected && mousePending));
	assign serviceReqN = !(irq && dataPhase) || irqInhibit;

	// No byte strobe while the host already sits in command phase
	assert property (@(posedge clk) disable iff (reset) doutStrobe |-> viaState != PhaseCmd);

endmodule

// File: adbKeyboard.sv
/* ADB keyboard at address 2. Only letters, Return, Space, Caps Lock and
   left Shift translate; all other PS/2 codes are dropped */
`timescale 1ns/1ps

module adbKeyboard #(
	parameter int KeyFifoDepthLog2 = 3
) (
	input logic clk,
	input logic reset,
	input logic [10:0] ps2Key, // Toggle, press, ps2Code
	input adbPkg::adbCmd curCmd,
	input adbPkg::adbAddr curAddr,
	input logic [3:0] respCnt,
	input adbPkg::adbPhase phase,
	input adbPkg::adbByte dinByte,
	input logic dinStrobe,
	output logic selected,
	output adbPkg::adbWord talkWord,
	output logic dataPending,
	output logic capsLock
);
	import adbPkg::*;

	localparam int FifoDepth = 2 ** KeyFifoDepthLog2;

	logic keyToggleR;
	logic keyToggled;
	logic keyPress;
	logic capsKey;
	logic keyStrobe;
	adbByte keyData; // Release flag and Mac key code
	adbByte keyFifo [FifoDepth];
	logic [KeyFifoDepthLog2:0] wrPtr;
	logic [KeyFifoDepthLog2:0] rdPtr;
	adbByte fifoHead;
	logic fifoEmpty;
	logic fifoFull;
	logic keyPush;
	logic keyPop;
	logic [1:0] keyCnt;
	adbWord reg0;
	adbWord reg2;
	devDataState state;
	adbRegSel regSel;
	logic cmdReset;
	logic cmdFlush;
	logic ledWrite;

	// PS/2 set 2 to Mac virtual key code
	function automatic keyCode translate(input ps2Code code);
		case (code)
			9'h01C: translate = 7'h00; // a
			9'h032: translate = 7'h0B; // b
			9'h021: translate = 7'h08;
			9'h023: translate = 7'h02;
			9'h024: translate = 7'h0E; // e
			9'h02B: translate = 7'h03;
			9'h034: translate = 7'h05;
			9'h033: translate = 7'h04; // h
			9'h043: translate = 7'h22;
			9'h03B: translate = 7'h26;
			9'h042: translate = 7'h28;
			9'h04B: translate = 7'h25; // l
			9'h03A: translate = 7'h2E;
			9'h031: translate = 7'h2D;
			9'h044: translate = 7'h1F; // o
			9'h04D: translate = 7'h23;
			9'h015: translate = 7'h0C;
			9'h02D: translate = 7'h0F;
			9'h01B: translate = 7'h01; // s
			9'h02C: translate = 7'h11;
			9'h03C: translate = 7'h20;
			9'h02A: translate = 7'h09; // v
			9'h01D: translate = 7'h0D;
			9'h022: translate = 7'h07;
			9'h035: translate = 7'h10;
			9'h01A: translate = 7'h06; // z
			9'h05A: translate = 7'h24; // Return
			9'h029: translate = 7'h31; // Space
			9'h058: translate = 7'h39; // Caps Lock
			9'h012: translate = 7'h38; // Left Shift
			default: translate = NoKey;
		endcase
	endfunction

	assign keyToggled = keyToggleR ^ ps2Key[10];
	assign keyPress = ps2Key[9];
	assign capsKey = ps2Key[8:0] == CapsLockCode;

	// Caps Lock latches like the Mac key: release is swallowed while set
	always_ff @(posedge clk) begin
		keyToggleR <= ps2Key[10];
		if (reset) begin
			keyStrobe <= 1'b0;
			capsLock <= 1'b0;
		end else begin
			keyStrobe <= 1'b0;
			if (keyToggled) begin
				if (capsKey && keyPress)
					capsLock <= ~capsLock;
				if (!(capsKey && capsLock))
					keyStrobe <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (keyToggled)
			keyData <= {~keyPress, translate(ps2Key[8:0])};
	end

	assign keyPush = keyStrobe && keyData[6:0] != NoKey;
	assign fifoEmpty = wrPtr == rdPtr;
	assign fifoFull = wrPtr == {~rdPtr[KeyFifoDepthLog2], rdPtr[KeyFifoDepthLog2-1:0]};
	assign fifoHead = keyFifo[rdPtr[KeyFifoDepthLog2-1:0]];

	always_ff @(posedge clk) begin
		if (keyPush)
			keyFifo[wrPtr[KeyFifoDepthLog2-1:0]] <= keyData;
	end

	assign selected = curAddr == KbdAddr;
	assign regSel = curCmd[1:0];
	assign cmdReset = curCmd == CmdReset; // Global, any address
	assign cmdFlush = selected && curCmd == CmdFlush;
	assign ledWrite = selected && curCmd == {CmdListen, 2'd2} && dinStrobe &&
		respCnt == 4'd0 && phase == PhaseEven;

	// At most two keys land in register 0 between reads
	assign keyPop = !fifoEmpty && phase == PhaseIdle && keyCnt < 2'd2 && state != DataSent;

	always_ff @(posedge clk) begin
		if (reset || cmdReset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			keyCnt <= '0;
			reg0 <= RegIdle;
			reg2 <= RegIdle;
			state <= DataNone;
		end else begin
			if (keyPush)
				wrPtr <= wrPtr + 1'b1;
			if (keyPop) begin
				rdPtr <= rdPtr + 1'b1;
				keyCnt <= keyCnt + 2'd1;
				state <= DataReady;
				if (reg0[6:0] == fifoHead[6:0])
					reg0[7:0] <= fifoHead;
				else if (reg0[14:8] == fifoHead[6:0])
					reg0[15:8] <= fifoHead;
				else if (reg0[7:0] == 8'hFF)
					reg0[7:0] <= fifoHead;
				else
					reg0[15:8] <= fifoHead;
			end

			if (ledWrite)
				reg2[2:0] <= dinByte[2:0]; // LED bits

			if (selected && state == DataReady && curCmd == {CmdTalk, 2'd0} && respCnt == 4'd2)
				state <= DataSent;

			if ((selected && state == DataSent && phase == PhaseCmd) || cmdFlush) begin
				state <= DataNone;
				keyCnt <= '0;
				reg0 <= RegIdle;
			end
			if (cmdFlush) begin
				wrPtr <= '0;
				rdPtr <= '0;
			end
		end
	end

	assign dataPending = state == DataReady;

	always_comb begin
		case (regSel)
			2'd0: talkWord = reg0;
			2'd2: talkWord = reg2;
			2'd3: talkWord = KbdReg3Default;
			default: talkWord = 16'h0000;
		endcase
	end

	// Eight queued events is the limit between polls
	assert property (@(posedge clk) disable iff (reset) keyPush |-> !fifoFull);

endmodule

// File: adbMouse.sv
/* ADB mouse at address 3. Deltas are clamped to 7 bits and Y is inverted
   for the Mac; ps2Mouse uses the usual 25-bit PS/2 packet layout */
`timescale 1ns/1ps

module adbMouse (
	input logic clk,
	input logic reset,
	input logic [24:0] ps2Mouse, // Toggle 24, dy 23:16, dx 15:8, signs 5:4, button 0
	input adbPkg::adbCmd curCmd,
	input adbPkg::adbAddr curAddr,
	input logic [3:0] respCnt,
	input adbPkg::adbPhase phase,
	output logic selected,
	output adbPkg::adbWord talkWord,
	output logic dataPending
);
	import adbPkg::*;

	logic toggleR;
	logic moved;
	mouseDelta dx;
	mouseDelta dy;
	logic [6:0] posX;
	logic [6:0] posY;
	logic button;
	devDataState state;
	adbRegSel regSel;
	logic cmdFlush;

	function automatic logic [6:0] clamp7(input logic signed [9:0] v);
		if (v > 10'sd63)
			clamp7 = 7'h3F;
		else if (v < -10'sd64)
			clamp7 = 7'h40;
		else
			clamp7 = v[6:0];
	endfunction

	assign moved = toggleR ^ ps2Mouse[24];
	assign dx = {ps2Mouse[4], ps2Mouse[15:8]};
	assign dy = {ps2Mouse[5], ps2Mouse[23:16]};

	assign selected = curAddr == MouseAddr;
	assign regSel = curCmd[1:0];
	assign cmdFlush = selected && curCmd == CmdFlush;

	always_ff @(posedge clk) begin
		toggleR <= ps2Mouse[24];
		if (reset || curCmd == CmdReset) begin
			posX <= '0;
			posY <= '0;
			button <= 1'b0;
			state <= DataNone;
		end else begin
			if (moved) begin
				posX <= clamp7(10'(dx));
				posY <= clamp7(-(10'(dy))); // PS/2 up is ADB negative
				button <= ps2Mouse[0];
				state <= DataReady;
			end
			if (selected && state == DataReady && respCnt == 4'd3)
				state <= DataSent;
			if ((selected && state == DataSent && phase == PhaseCmd) || cmdFlush) begin
				state <= DataNone;
				posX <= '0;
				posY <= '0;
			end
		end
	end

	assign dataPending = state == DataReady;

	always_comb begin
		case (regSel)
			2'd0: talkWord = {~button, posY, 1'b1, posX}; // Button bit is active low
			2'd3: talkWord = MouseReg3Default;
			default: talkWord = 16'h0000;
		endcase
	end

endmodule

// File: adbPkg.sv
/* Shared ADB types, phase and data-state enums, and register defaults.
   Device addresses are fixed, so register 3 is read-only here */
package adbPkg;

	typedef logic [7:0] adbByte;
	typedef logic [15:0] adbWord;
	typedef logic [3:0] adbAddr;
	typedef logic [3:0] adbCmd; // Talk 11rr, Listen 10rr, Flush 0001, Reset 0000
	typedef logic [1:0] adbRegSel;
	typedef logic [6:0] keyCode;
	typedef logic [8:0] ps2Code; // Bit 8 set for E0 extended codes
	typedef logic signed [8:0] mouseDelta;

	// Same encoding as the VIA state lines
	typedef enum logic [1:0] {
		PhaseCmd = 2'b00,
		PhaseEven = 2'b01,
		PhaseOdd = 2'b10,
		PhaseIdle = 2'b11
	} adbPhase;

	typedef enum logic [1:0] {
		DataNone, // Nothing to report
		DataReady, // New data waiting for a talk
		DataSent // Talk has read it, cleared at next command
	} devDataState;

	localparam adbCmd CmdReset = 4'b0000;
	localparam adbCmd CmdFlush = 4'b0001;
	localparam logic [1:0] CmdListen = 2'b10; // Upper bits of the command
	localparam logic [1:0] CmdTalk = 2'b11;

	localparam adbAddr KbdAddr = 4'd2;
	localparam adbAddr MouseAddr = 4'd3;

	// Register 3: exceptional event, SRQ enable, address, handler ID
	localparam adbWord KbdReg3Default = 16'h6202;
	localparam adbWord MouseReg3Default = 16'h6301;

	localparam adbWord RegIdle = 16'hFFFF;
	localparam keyCode NoKey = 7'h7F;
	localparam ps2Code CapsLockCode = 9'h058;

endpackage

// File: adbTop.sv
/* ADB device side: keyboard at 2 and mouse at 3 behind a VIA shift
   register. TalkInterval is in clock cycles */
`timescale 1ns/1ps

module adbTop #(
	parameter int TalkInterval = 88000,
	parameter int KeyFifoDepthLog2 = 3
) (
	input logic clk,
	input logic reset,
	input adbPkg::adbPhase viaState,
	input logic viaBusy,
	input adbPkg::adbByte dinByte,
	input logic dinStrobe,
	input logic [10:0] ps2Key,
	input logic [24:0] ps2Mouse,
	output adbPkg::adbByte doutByte,
	output logic doutStrobe,
	output logic listen,
	output logic serviceReqN,
	output logic capsLock
);
	import adbPkg::*;

	adbCmd curCmd;
	adbAddr curAddr;
	logic [3:0] respCnt;
	adbPhase phase;
	logic kbdSelected;
	adbWord kbdTalkWord;
	logic kbdPending;
	logic mouseSelected;
	adbWord mouseTalkWord;
	logic mousePending;

	adbBusCtrl #(
		.TalkInterval(TalkInterval)
	) busCtrl_i (
		.clk(clk), .reset(reset), .viaState(viaState), .viaBusy(viaBusy),
		.dinByte(dinByte), .dinStrobe(dinStrobe),
		.kbdSelected(kbdSelected), .kbdTalkWord(kbdTalkWord), .kbdPending(kbdPending),
		.mouseSelected(mouseSelected), .mouseTalkWord(mouseTalkWord),
		.mousePending(mousePending),
		.curCmd(curCmd), .curAddr(curAddr), .respCnt(respCnt), .phase(phase),
		.doutByte(doutByte), .doutStrobe(doutStrobe), .listen(listen),
		.serviceReqN(serviceReqN)
	);

	adbKeyboard #(
		.KeyFifoDepthLog2(KeyFifoDepthLog2)
	) keyboard_i (
		.clk(clk), .reset(reset), .ps2Key(ps2Key),
		.curCmd(curCmd), .curAddr(curAddr), .respCnt(respCnt), .phase(phase),
		.dinByte(dinByte), .dinStrobe(dinStrobe),
		.selected(kbdSelected), .talkWord(kbdTalkWord), .dataPending(kbdPending),
		.capsLock(capsLock)
	);

	adbMouse mouse_i (
		.clk(clk), .reset(reset), .ps2Mouse(ps2Mouse),
		.curCmd(curCmd), .curAddr(curAddr), .respCnt(respCnt), .phase(phase),
		.selected(mouseSelected), .talkWord(mouseTalkWord), .dataPending(mousePending)
	);

endmodule

// File: tbAdb.sv
/* Directed testbench for adbTop with a short talk interval. Inputs change on the
   rising edge and DUT outputs are sampled on the falling edge */
`timescale 1ns/1ps

module tbAdb;
	import adbPkg::*;

	localparam int TalkInterval = 40;
	// Each test runs a few hundred cycles, autopoll waits up to two intervals
	localparam int TimeoutCycles = 20000;
	localparam int StrobeWait = 40; // Longest busy hold plus response latency

	logic clk = 1'b0;
	logic reset;
	adbPhase viaState;
	logic viaBusy;
	adbByte dinByte;
	logic dinStrobe;
	logic [10:0] ps2Key;
	logic [24:0] ps2Mouse;
	adbByte doutByte;
	logic doutStrobe;
	logic listen;
	logic serviceReqN;
	logic capsLock;

	logic [15:0] lfsrState = 16'd18771;
	int cycleCount = 0;
	int strobeCount = 0;
	adbByte lastByte;
	logic srqAtStrobe;

	adbTop #(
		.TalkInterval(TalkInterval),
		.KeyFifoDepthLog2(3)
	) dut_i (
		.clk(clk), .reset(reset), .viaState(viaState), .viaBusy(viaBusy),
		.dinByte(dinByte), .dinStrobe(dinStrobe), .ps2Key(ps2Key), .ps2Mouse(ps2Mouse),
		.doutByte(doutByte), .doutStrobe(doutStrobe), .listen(listen),
		.serviceReqN(serviceReqN), .capsLock(capsLock)
	);

	always #10 clk = ~clk;

	task automatic stopWithFail(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "Run stopped on the first error");
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
			stopWithFail($sformatf("Timeout: no progress after %0d cycles", cycleCount));
	end

	// Bus byte log, read by the tasks on the next rising edge
	always @(negedge clk) begin
		if (!reset && doutStrobe) begin
			strobeCount = strobeCount + 1;
			lastByte = doutByte;
			srqAtStrobe = serviceReqN;
		end
	end

	// Galois LFSR, one step per bit taken
	function automatic int randBits(input int n);
		int v;
		logic lsb;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (lsb)
				lfsrState = lfsrState ^ 16'hB400;
			v = (v << 1) | int'(lsb);
		end
		return v;
	endfunction

	task automatic checkByte(input string name, input adbByte exp, input adbByte act);
		if (exp !== act)
			stopWithFail($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkWord(input string name, input adbWord exp, input adbWord act);
		if (exp !== act)
			stopWithFail($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (exp !== act)
			stopWithFail($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic busCmd(input adbAddr addr, input adbCmd cmd);
		@(posedge clk);
		viaState <= PhaseCmd;
		viaBusy <= 1'b0;
		@(posedge clk);
		dinByte <= {addr, cmd};
		dinStrobe <= 1'b1;
		@(posedge clk);
		dinStrobe <= 1'b0;
		@(posedge clk);
	endtask

	// One data phase, random busy hold first, then exactly one byte expected
	task automatic takeByte(input string name, input adbPhase ph, output adbByte b);
		int startCount;
		int hold;
		int waited;
		hold = randBits(3);
		startCount = strobeCount;
		@(posedge clk);
		viaState <= ph;
		viaBusy <= 1'b1;
		repeat (hold) @(posedge clk);
		viaBusy <= 1'b0;
		waited = 0;
		while (strobeCount == startCount) begin
			@(posedge clk);
			waited++;
			if (waited > StrobeWait)
				stopWithFail($sformatf("%s: no talk byte came in the data phase", name));
		end
		b = lastByte;
		repeat (3) @(posedge clk);
		if (strobeCount != startCount + 1)
			stopWithFail($sformatf("%s: talk byte was strobed more than once", name));
	endtask

	task automatic talkReg(input string name, input adbAddr addr, input adbRegSel r,
			input adbWord exp);
		adbByte hi;
		adbByte lo;
		busCmd(addr, {2'b11, r});
		takeByte(name, PhaseEven, hi);
		takeByte(name, PhaseOdd, lo);
		checkWord(name, exp, {hi, lo});
	endtask

	task automatic enterIdle();
		@(posedge clk);
		viaState <= PhaseIdle;
		repeat (2) @(posedge clk);
	endtask

	task automatic keyEvent(input logic press, input ps2Code code);
		@(posedge clk);
		ps2Key <= {~ps2Key[10], press, code};
		repeat (4) @(posedge clk); // FIFO push and idle pop
	endtask

	task automatic mouseEvent(input int dx, input int dy, input logic button);
		logic [8:0] x;
		logic [8:0] y;
		x = 9'(dx);
		y = 9'(dy);
		@(posedge clk);
		ps2Mouse <= {~ps2Mouse[24], y[7:0], x[7:0], 2'b00, y[8], x[8], 3'b000, button};
		repeat (2) @(posedge clk);
	endtask

	// ADB delta is 7-bit two's complement, saturating
	function automatic logic [6:0] limitDelta(input int v);
		if (v > 63)
			return 7'h3F;
		if (v < -64)
			return 7'h40;
		return 7'(v);
	endfunction

	task automatic waitAutopoll(input string name, input int limit);
		int startCount;
		int n;
		startCount = strobeCount;
		@(posedge clk);
		viaState <= PhaseIdle;
		n = 0;
		while (strobeCount == startCount) begin
			@(posedge clk);
			n++;
			if (n > limit + 1) // Log is read one edge after the strobe
				stopWithFail($sformatf("%s: no autopoll byte within %0d cycles", name, limit));
		end
		checkByte(name, 8'hFF, lastByte);
	endtask

	task automatic readRegister3();
		talkReg("kbd reg3", KbdAddr, 2'd3, 16'h6202);
		talkReg("mouse reg3", MouseAddr, 2'd3, 16'h6301);
		talkReg("absent device", 4'd5, 2'd3, 16'hFFFF);
		enterIdle();
	endtask

	task automatic keyPressReport();
		keyEvent(1'b1, 9'h01C); // a, Mac code 00
		keyEvent(1'b1, 9'h076); // Escape is not in the table
		keyEvent(1'b0, 9'h01C); // Release replaces the matching half
		talkReg("mouse talk srq", MouseAddr, 2'd3, 16'h6301);
		checkBit("srq with key pending", 1'b0, srqAtStrobe);
		talkReg("kbd reg0 a", KbdAddr, 2'd0, 16'hFF80);
	endtask

	task automatic listenThenReset();
		adbByte b;
		busCmd(KbdAddr, 4'b1010);
		@(posedge clk);
		viaState <= PhaseEven;
		@(posedge clk);
		dinByte <= 8'h05;
		dinStrobe <= 1'b1;
		@(negedge clk);
		checkBit("listen flag", 1'b1, listen);
		@(posedge clk);
		dinStrobe <= 1'b0;
		@(posedge clk);
		talkReg("kbd reg2 leds", KbdAddr, 2'd2, 16'hFFFD);
		busCmd(4'd0, CmdReset);
		takeByte("reset byte", PhaseEven, b);
		checkByte("reset byte", 8'hFF, b);
		talkReg("kbd reg2 after reset", KbdAddr, 2'd2, 16'hFFFF);
	endtask

	task automatic mouseDeltaClamp();
		adbByte b;
		int dx;
		int dy;
		logic btn;
		for (int i = 0; i < 4; i++) begin
			dx = randBits(9);
			dy = randBits(9);
			btn = randBits(1);
			if (dx >= 256)
				dx -= 512;
			if (dy >= 256)
				dy -= 512;
			mouseEvent(dx, dy, btn);
			talkReg("mouse reg0", MouseAddr, 2'd0,
				{~btn, limitDelta(-dy), 1'b1, limitDelta(dx)});
			takeByte("mouse trailing byte", PhaseEven, b); // Third byte marks it read
			checkByte("mouse trailing byte", 8'hFF, b);
			talkReg("mouse reg0 cleared", MouseAddr, 2'd0, {~btn, 7'h00, 1'b1, 7'h00});
		end
	endtask

	task automatic capsLockLatch();
		enterIdle();
		keyEvent(1'b1, CapsLockCode);
		checkBit("caps press 1", 1'b1, capsLock);
		keyEvent(1'b0, CapsLockCode);
		checkBit("caps release 1", 1'b1, capsLock);
		keyEvent(1'b1, CapsLockCode);
		checkBit("caps press 2", 1'b0, capsLock);
		keyEvent(1'b0, CapsLockCode);
		checkBit("caps release 2", 1'b0, capsLock);
		// Press 39 then release B9 in the same half
		talkReg("kbd reg0 caps", KbdAddr, 2'd0, 16'hFFB9);
	endtask

	task automatic autopollAndFlush();
		adbByte b;
		talkReg("autopoll new cmd", MouseAddr, 2'd3, 16'h6301);
		waitAutopoll("autopoll new cmd", TalkInterval + 2);
		talkReg("autopoll same cmd", MouseAddr, 2'd3, 16'h6301);
		waitAutopoll("autopoll same cmd", 2 * TalkInterval + 2);
		keyEvent(1'b1, 9'h032); // b
		busCmd(KbdAddr, CmdFlush);
		takeByte("flush byte", PhaseEven, b);
		checkByte("flush byte", 8'hFF, b);
		talkReg("kbd reg0 after flush", KbdAddr, 2'd0, 16'hFFFF);
		enterIdle();
	endtask

	initial begin
		reset = 1'b1;
		viaState = PhaseIdle;
		viaBusy = 1'b0;
		dinByte = 8'h00;
		dinStrobe = 1'b0;
		ps2Key = '0;
		ps2Mouse = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkBit("reset doutStrobe", 1'b0, doutStrobe);
		checkBit("reset listen", 1'b0, listen);
		checkBit("reset capsLock", 1'b0, capsLock);
		readRegister3();
		keyPressReport();
		listenThenReset();
		mouseDeltaClamp();
		capsLockLatch();
		autopollAndFlush();
		$display("all tests passed");
		$finish;
	end

endmodule

// File: vlog.f
adbPkg.sv
adbBusCtrl.sv
adbKeyboard.sv
adbMouse.sv
adbTop.sv
tbAdb.sv
